// File: hw/rx_core_settings.svh
`ifndef RX_CORE_SETTINGS_SVH
`define RX_CORE_SETTINGS_SVH

// Datapath geometry
`define NTI      4
`define NADC     8
`define NPI      9
`define CAL_LOG2 4

// Register word addresses
`define REG_CTRL       4'd0
`define REG_PI_OFFSET  4'd1
`define REG_CDR_STEP   4'd2
`define REG_EXT_OFS0   4'd3
`define REG_OFS0       4'd8
`define REG_PI_CTL     4'd12
`define REG_PRBS_TOTAL 4'd13
`define REG_PRBS_ERR   4'd14

`endif

// File: hw/rx_core_pkg.sv
`include "rx_core_settings.svh"

package rx_core_pkg;

    // Raw ADC magnitude code
    typedef logic [`NADC-1:0] adc_mag_t;

    // Unfolded sample with the offset already removed
    typedef logic signed [`NADC+1:0] sample_t;

    // Per-slice comparator offset
    typedef logic signed [`NADC+1:0] offset_t;

    // Phase interpolator code that wraps around
    typedef logic [`NPI-1:0] pi_ctl_t;

    typedef logic [3:0] pi_step_t;

    // Bit counters
    typedef logic [31:0] count_t;

    // Wishbone word address and data
    typedef logic [3:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

endpackage

// File: hw/adc_retimer.sv
`timescale 1ns/1ps
`include "rx_core_settings.svh"
`default_nettype none

module adc_retimer (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire rx_core_pkg::adc_mag_t mag_i [`NTI],
    input  wire logic [`NTI-1:0]       sign_i,
    output rx_core_pkg::adc_mag_t      mag_o [`NTI],
    output logic [`NTI-1:0]            sign_o
);

    // All slices captured on the same edge into one parallel word
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            sign_o <= '0;
            for (int k = 0; k < `NTI; k++) begin
                mag_o[k] <= '0;
            end
        end else begin
            sign_o <= sign_i;
            for (int k = 0; k < `NTI; k++) begin
                mag_o[k] <= mag_i[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/adc_unfolder.sv
`timescale 1ns/1ps
`include "rx_core_settings.svh"
`default_nettype none

module adc_unfolder (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire rx_core_pkg::adc_mag_t mag_i,
    input  wire logic                  sign_i,
    input  wire logic                  cal_en_i,
    input  wire rx_core_pkg::offset_t  ext_offset_i,
    output rx_core_pkg::sample_t       sample_o,
    output rx_core_pkg::offset_t       offset_o
);
    import rx_core_pkg::*;

    // Wide enough for a full window of raw samples
    typedef logic signed [`NADC+1+`CAL_LOG2:0] cal_sum_t;

    sample_t              raw;
    offset_t              active_ofs;
    offset_t              cal_ofs;
    cal_sum_t             cal_sum;
    cal_sum_t             sum_next;
    logic [`CAL_LOG2-1:0] cal_cnt;

    // Sign high means positive
    assign raw = sign_i ? sample_t'({2'b00, mag_i}) : -sample_t'({2'b00, mag_i});

    assign active_ofs = cal_en_i ? cal_ofs : ext_offset_i;
    assign sum_next   = cal_sum + cal_sum_t'(raw);

    // Calibrated value stays visible even when the external offset is active
    assign offset_o = cal_ofs;

    always_ff @(posedge clk_adc) begin
        sample_o <= raw - active_ofs;
    end

    // Running average over 2^CAL_LOG2 samples
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            cal_cnt <= '0;
            cal_sum <= '0;
            cal_ofs <= '0;
        end else if (cal_en_i) begin
            cal_cnt <= cal_cnt + 1'b1;
            if (&cal_cnt) begin
                // Window end so load the mean
                cal_ofs <= offset_t'(sum_next >>> `CAL_LOG2);
                cal_sum <= '0;
            end else begin
                cal_sum <= sum_next;
            end
        end else begin
            cal_cnt <= '0;
            cal_sum <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/mm_cdr.sv
`timescale 1ns/1ps
`include "rx_core_settings.svh"
`default_nettype none

module mm_cdr (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire logic                  cdr_en_i,
    input  wire rx_core_pkg::sample_t  sample_i [`NTI],
    input  wire logic [`NTI-1:0]       bit_i,
    input  wire rx_core_pkg::pi_step_t step_i,
    input  wire rx_core_pkg::pi_ctl_t  pi_offset_i,
    output rx_core_pkg::pi_ctl_t       pi_ctl_o
);
    import rx_core_pkg::*;

    // Sum of NTI terms of up to twice a sample each
    typedef logic signed [`NADC+2+$clog2(`NTI):0] pd_sum_t;

    sample_t         last_sample_q;
    logic            last_bit_q;
    sample_t         prev_s [`NTI];
    logic [`NTI-1:0] prev_d;
    pd_sum_t         pd_sum_d;
    pd_sum_t         pd_sum_q;
    logic            pd_pos;
    logic            pd_neg;
    pi_ctl_t         acc_q;
    pi_ctl_t         acc_d;

    // Sample times the decision, which is +1 or -1
    function automatic pd_sum_t weigh(input sample_t s, input logic d);
        return d ? pd_sum_t'(s) : -pd_sum_t'(s);
    endfunction

    // Neighbour k-1 of slice 0 is the last slice of the previous word
    assign prev_d = {bit_i[`NTI-2:0], last_bit_q};

    always_comb begin
        prev_s[0] = last_sample_q;
        for (int k = 1; k < `NTI; k++) begin
            prev_s[k] = sample_i[k-1];
        end
    end

    // Mueller-Muller term s[k]*d[k-1] - s[k-1]*d[k] summed over the word
    always_comb begin
        pd_sum_d = '0;
        for (int k = 0; k < `NTI; k++) begin
            pd_sum_d = pd_sum_d + weigh(sample_i[k], prev_d[k]) - weigh(prev_s[k], bit_i[k]);
        end
    end

    always_ff @(posedge clk_adc) begin
        last_sample_q <= sample_i[`NTI-1];
        last_bit_q    <= bit_i[`NTI-1];
    end

    assign pd_neg = pd_sum_q[$bits(pd_sum_t)-1];
    assign pd_pos = !pd_neg && (pd_sum_q != '0);

    // Bang-bang accumulator
    always_comb begin
        acc_d = acc_q;
        if (cdr_en_i) begin
            if (pd_pos) begin
                acc_d = acc_q + pi_ctl_t'(step_i);
            end else if (pd_neg) begin
                acc_d = acc_q - pi_ctl_t'(step_i);
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            pd_sum_q <= '0;
            acc_q    <= '0;
            pi_ctl_o <= '0;
        end else begin
            pd_sum_q <= pd_sum_d;
            acc_q    <= acc_d;
            pi_ctl_o <= acc_d + pi_offset_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/prbs_checker.sv
`timescale 1ns/1ps
`include "rx_core_settings.svh"
`default_nettype none

module prbs_checker (
    input  wire logic            clk_adc,
    input  wire logic            reset_i,
    input  wire logic            clear_i,
    input  wire logic [`NTI-1:0] bit_i,
    output rx_core_pkg::count_t  total_o,
    output rx_core_pkg::count_t  errors_o
);
    import rx_core_pkg::*;

    // Holds 0 to NTI
    typedef logic [$clog2(`NTI):0] bit_cnt_t;

    // hist[0] holds the newest received bit and hist[6] the one seven back
    logic [6:0] hist_q;
    logic [6:0] hist_d;
    logic [2:0] fill_q;
    logic [2:0] fill_d;
    bit_cnt_t   n_valid;
    bit_cnt_t   n_err;

    // Walk the word from the oldest bit in slice 0
    always_comb begin
        hist_d  = hist_q;
        fill_d  = fill_q;
        n_valid = '0;
        n_err   = '0;
        for (int k = 0; k < `NTI; k++) begin
            if (fill_d == 3'd7) begin
                n_valid = n_valid + bit_cnt_t'(1);
                // PRBS7 x^7 + x^6 + 1
                if (bit_i[k] != (hist_d[5] ^ hist_d[6])) begin
                    n_err = n_err + bit_cnt_t'(1);
                end
            end else begin
                fill_d = fill_d + 3'd1;
            end
            hist_d = {hist_d[5:0], bit_i[k]};
        end
    end

    // Received bit history for the predictor
    always_ff @(posedge clk_adc) begin
        hist_q <= hist_d;
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i || clear_i) begin
            fill_q   <= '0;
            total_o  <= '0;
            errors_o <= '0;
        end else begin
            fill_q   <= fill_d;
            total_o  <= total_o + count_t'(n_valid);
            errors_o <= errors_o + count_t'(n_err);
        end
    end

endmodule

`default_nettype wire

// File: hw/wb_regs.sv
`timescale 1ns/1ps
`include "rx_core_settings.svh"
`default_nettype none

module wb_regs (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire logic                  wb_cyc_i,
    input  wire logic                  wb_stb_i,
    input  wire logic                  wb_we_i,
    input  wire rx_core_pkg::wb_addr_t wb_adr_i,
    input  wire rx_core_pkg::wb_data_t wb_dat_i,
    input  wire rx_core_pkg::offset_t  offset_i [`NTI],
    input  wire rx_core_pkg::pi_ctl_t  pi_ctl_i,
    input  wire rx_core_pkg::count_t   prbs_total_i,
    input  wire rx_core_pkg::count_t   prbs_errors_i,
    output rx_core_pkg::wb_data_t      wb_dat_o,
    output logic                       wb_ack_o,
    output logic                       cal_en_o,
    output logic                       cdr_en_o,
    output logic                       prbs_clear_o,
    output rx_core_pkg::pi_ctl_t       pi_offset_o,
    output rx_core_pkg::pi_step_t      cdr_step_o,
    output rx_core_pkg::offset_t       ext_offset_o [`NTI]
);
    import rx_core_pkg::*;

    logic     req;
    logic     wr;
    wb_data_t rd_data;

    function automatic wb_data_t sext_ofs(input offset_t o);
        return {{($bits(wb_data_t)-$bits(offset_t)){o[$bits(offset_t)-1]}}, o};
    endfunction

    // A pending ack blocks the next request so each one is acked once
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr  = req && wb_we_i;

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            `REG_CTRL:       rd_data = {30'd0, cdr_en_o, cal_en_o};
            `REG_PI_OFFSET:  rd_data = wb_data_t'(pi_offset_o);
            `REG_CDR_STEP:   rd_data = wb_data_t'(cdr_step_o);
            `REG_PI_CTL:     rd_data = wb_data_t'(pi_ctl_i);
            `REG_PRBS_TOTAL: rd_data = prbs_total_i;
            `REG_PRBS_ERR:   rd_data = prbs_errors_i;
            default:         rd_data = '0;
        endcase
        // Per-slice offset banks
        for (int k = 0; k < `NTI; k++) begin
            if (wb_adr_i == wb_addr_t'(`REG_EXT_OFS0 + k)) begin
                rd_data = sext_ofs(ext_offset_o[k]);
            end
            if (wb_adr_i == wb_addr_t'(`REG_OFS0 + k)) begin
                rd_data = sext_ofs(offset_i[k]);
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            wb_ack_o     <= 1'b0;
            wb_dat_o     <= '0;
            cal_en_o     <= 1'b0;
            cdr_en_o     <= 1'b0;
            prbs_clear_o <= 1'b0;
            pi_offset_o  <= '0;
            cdr_step_o   <= '0;
            for (int k = 0; k < `NTI; k++) begin
                ext_offset_o[k] <= '0;
            end
        end else begin
            wb_ack_o     <= req;
            wb_dat_o     <= (req && !wb_we_i) ? rd_data : '0;
            prbs_clear_o <= 1'b0;
            if (wr) begin
                case (wb_adr_i)
                    `REG_CTRL: begin
                        cal_en_o     <= wb_dat_i[0];
                        cdr_en_o     <= wb_dat_i[1];
                        prbs_clear_o <= wb_dat_i[2];
                    end
                    `REG_PI_OFFSET: pi_offset_o <= pi_ctl_t'(wb_dat_i);
                    `REG_CDR_STEP:  cdr_step_o <= pi_step_t'(wb_dat_i);
                    default: ;
                endcase
                for (int k = 0; k < `NTI; k++) begin
                    if (wb_adr_i == wb_addr_t'(`REG_EXT_OFS0 + k)) begin
                        ext_offset_o[k] <= offset_t'(wb_dat_i);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rx_core.sv
`timescale 1ns/1ps
`include "rx_core_settings.svh"
`default_nettype none

module rx_core (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire rx_core_pkg::adc_mag_t adc_mag_i [`NTI],
    input  wire logic [`NTI-1:0]       adc_sign_i,
    output wire logic [`NTI-1:0]       data_bits_o,
    output wire rx_core_pkg::pi_ctl_t  pi_ctl_o,
    input  wire logic                  wb_cyc_i,
    input  wire logic                  wb_stb_i,
    input  wire logic                  wb_we_i,
    input  wire rx_core_pkg::wb_addr_t wb_adr_i,
    input  wire rx_core_pkg::wb_data_t wb_dat_i,
    output wire rx_core_pkg::wb_data_t wb_dat_o,
    output wire logic                  wb_ack_o
);
    import rx_core_pkg::*;

    wire adc_mag_t        ret_mag [`NTI];
    wire logic [`NTI-1:0] ret_sign;
    wire sample_t         sample [`NTI];
    wire offset_t         cal_offset [`NTI];
    wire offset_t         ext_offset [`NTI];
    wire logic            cal_en;
    wire logic            cdr_en;
    wire logic            prbs_clear;
    wire pi_ctl_t         pi_offset;
    wire pi_step_t        cdr_step;
    wire count_t          prbs_total;
    wire count_t          prbs_errors;

    adc_retimer i_retimer (
        .clk_adc (clk_adc),
        .reset_i (reset_i),
        .mag_i   (adc_mag_i),
        .sign_i  (adc_sign_i),
        .mag_o   (ret_mag),
        .sign_o  (ret_sign)
    );

    for (genvar k = 0; k < `NTI; k++) begin : g_slice
        adc_unfolder i_unfolder (
            .clk_adc      (clk_adc),
            .reset_i      (reset_i),
            .mag_i        (ret_mag[k]),
            .sign_i       (ret_sign[k]),
            .cal_en_i     (cal_en),
            .ext_offset_i (ext_offset[k]),
            .sample_o     (sample[k]),
            .offset_o     (cal_offset[k])
        );

        // Decision is the sign of the sample
        assign data_bits_o[k] = ~sample[k][`NADC+1];
    end

    mm_cdr i_cdr (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .cdr_en_i    (cdr_en),
        .sample_i    (sample),
        .bit_i       (data_bits_o),
        .step_i      (cdr_step),
        .pi_offset_i (pi_offset),
        .pi_ctl_o    (pi_ctl_o)
    );

    prbs_checker i_prbs (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .clear_i  (prbs_clear),
        .bit_i    (data_bits_o),
        .total_o  (prbs_total),
        .errors_o (prbs_errors)
    );

    wb_regs i_regs (
        .clk_adc       (clk_adc),
        .reset_i       (reset_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .offset_i      (cal_offset),
        .pi_ctl_i      (pi_ctl_o),
        .prbs_total_i  (prbs_total),
        .prbs_errors_i (prbs_errors),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .cal_en_o      (cal_en),
        .cdr_en_o      (cdr_en),
        .prbs_clear_o  (prbs_clear),
        .pi_offset_o   (pi_offset),
        .cdr_step_o    (cdr_step),
        .ext_offset_o  (ext_offset)
    );

endmodule

`default_nettype wire

// File: sim/tb_rx_core.sv
`timescale 1ns/1ps
`include "rx_core_settings.svh"

module tb_rx_core;
    import rx_core_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int ACK_LIMIT     = 16;
    localparam int UNFOLD_ITER   = 40;
    localparam int PRBS_WORDS    = 400;
    localparam int CDR_STEP      = 4;
    localparam int PI_OFS        = 37;
    // Rough cycle budget per test
    localparam int REG_CYCLES    = 150;
    localparam int UNFOLD_CYCLES = 3 * UNFOLD_ITER + 30;
    localparam int CAL_CYCLES    = 80;
    localparam int PRBS_CYCLES   = 2 * (PRBS_WORDS + 30);
    localparam int CDR_CYCLES    = 120;
    localparam int WATCHDOG_CYCLES =
        REG_CYCLES + UNFOLD_CYCLES + CAL_CYCLES + PRBS_CYCLES + CDR_CYCLES + 500;

    logic            clk_adc;
    logic            reset_i;
    adc_mag_t        adc_mag [`NTI];
    logic [`NTI-1:0] adc_sign;
    logic [`NTI-1:0] data_bits;
    pi_ctl_t         pi_ctl;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    wb_addr_t        wb_adr;
    wb_data_t        wb_dat_i;
    wb_data_t        wb_dat_o;
    logic            wb_ack;

    logic [31:0] lfsr;
    logic [6:0]  prbs_state;
    int          words_sent;
    int          errors;
    int          checks;

    rx_core i_rx_core (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .adc_mag_i   (adc_mag),
        .adc_sign_i  (adc_sign),
        .data_bits_o (data_bits),
        .pi_ctl_o    (pi_ctl),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack)
    );

    initial begin
        clk_adc = 1'b0;
        forever #(CLK_PERIOD / 2) clk_adc = ~clk_adc;
    end

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // PRBS7 x^7 + x^6 + 1 with state[0] as the newest bit
    function automatic logic prbs_next();
        logic b;
        b = prbs_state[6] ^ prbs_state[5];
        prbs_state = {prbs_state[5:0], b};
        return b;
    endfunction

    task automatic wait_ack(input string who);
        int n;
        n = 0;
        do begin
            @(negedge clk_adc);
            n++;
        end while (!wb_ack && n < ACK_LIMIT);
        if (!wb_ack) begin
            $display("%s: no Wishbone ack for address %0d", who, wb_adr);
            errors++;
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        @(negedge clk_adc);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = dat;
        wait_ack("wb_write");
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        @(negedge clk_adc);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack("wb_read");
        dat    = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic read_check(input string name, input wb_addr_t adr, input wb_data_t exp);
        wb_data_t act;
        wb_read(adr, act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_pi_port(input string name, input pi_ctl_t exp);
        checks++;
        if (pi_ctl !== exp) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, pi_ctl);
            errors++;
        end
    endtask

    task automatic register_access();
        wb_data_t ext_val [`NTI];
        wb_data_t ext_exp [`NTI];
        ext_val = '{32'h345, 32'h0ff, 32'hfffffe01, 32'h1ff};
        // Ten-bit offsets read back sign-extended
        ext_exp = '{32'hffffff45, 32'h0ff, 32'hfffffe01, 32'h1ff};
        read_check("reset ctrl", `REG_CTRL, '0);
        read_check("reset pi_offset", `REG_PI_OFFSET, '0);
        read_check("reset cdr_step", `REG_CDR_STEP, '0);
        for (int k = 0; k < `NTI; k++) begin
            read_check("reset ext_ofs", wb_addr_t'(`REG_EXT_OFS0 + k), '0);
        end
        read_check("unmapped 7", wb_addr_t'(7), '0);
        read_check("unmapped 15", wb_addr_t'(15), '0);
        // Clear bit is a pulse and reads back low
        wb_write(`REG_CTRL, 32'h7);
        read_check("ctrl readback", `REG_CTRL, 32'h3);
        wb_write(`REG_CTRL, 32'h0);
        read_check("ctrl cleared", `REG_CTRL, '0);
        wb_write(`REG_PI_OFFSET, 32'hfffffe5a);
        read_check("pi_offset", `REG_PI_OFFSET, 32'hfffffe5a & wb_data_t'((1 << `NPI) - 1));
        wb_write(`REG_CDR_STEP, 32'h2b);
        read_check("cdr_step", `REG_CDR_STEP, 32'hb);
        for (int k = 0; k < `NTI; k++) begin
            wb_write(wb_addr_t'(`REG_EXT_OFS0 + k), ext_val[k]);
        end
        for (int k = 0; k < `NTI; k++) begin
            read_check("ext_ofs", wb_addr_t'(`REG_EXT_OFS0 + k), ext_exp[k]);
        end
        wb_write(wb_addr_t'(7), 32'hdeadbeef);
        read_check("unmapped write", wb_addr_t'(7), '0);
        wb_write(`REG_PI_OFFSET, '0);
        wb_write(`REG_CDR_STEP, '0);
        for (int k = 0; k < `NTI; k++) begin
            wb_write(wb_addr_t'(`REG_EXT_OFS0 + k), '0);
        end
    endtask

    task automatic unfold_with_offset();
        offset_t         ofs [`NTI];
        logic [`NTI-1:0] exp_bits;
        int              raw;
        wb_write(`REG_CTRL, '0);
        for (int k = 0; k < `NTI; k++) begin
            ofs[k] = offset_t'(int'(rand_bits(7)) - 64);
            wb_write(wb_addr_t'(`REG_EXT_OFS0 + k), wb_data_t'(ofs[k]));
        end
        for (int i = 0; i < UNFOLD_ITER; i++) begin
            @(negedge clk_adc);
            for (int k = 0; k < `NTI; k++) begin
                adc_mag[k]  = adc_mag_t'(rand_bits(8));
                adc_sign[k] = rand_bits(1) != 0;
                raw = adc_sign[k] ? int'(adc_mag[k]) : -int'(adc_mag[k]);
                exp_bits[k] = (raw - int'(ofs[k])) >= 0;
            end
            // Retimer plus unfolder
            repeat (2) @(negedge clk_adc);
            checks++;
            if (data_bits !== exp_bits) begin
                $display("CHECK FAILED unfold: expected %b, actual %b", exp_bits, data_bits);
                errors++;
            end
        end
    endtask

    task automatic offset_calibration();
        int cal_val [`NTI];
        cal_val = '{12, -7, 100, -1};
        @(negedge clk_adc);
        for (int k = 0; k < `NTI; k++) begin
            adc_mag[k]  = adc_mag_t'(cal_val[k] < 0 ? -cal_val[k] : cal_val[k]);
            adc_sign[k] = cal_val[k] >= 0;
        end
        repeat (3) @(negedge clk_adc);
        wb_write(`REG_CTRL, 32'h1);
        repeat (2 * (1 << `CAL_LOG2) + 8) @(negedge clk_adc);
        for (int k = 0; k < `NTI; k++) begin
            read_check("cal offset", wb_addr_t'(`REG_OFS0 + k), wb_data_t'(cal_val[k]));
        end
        // Calibrated samples sit at zero and decide high
        checks++;
        if (data_bits !== {`NTI{1'b1}}) begin
            $display("CHECK FAILED cal bits: expected %b, actual %b", {`NTI{1'b1}}, data_bits);
            errors++;
        end
        wb_write(`REG_CTRL, '0);
    endtask

    task automatic prbs_run(input string name, input int flip0, input int flip1,
                            input int flip2, input wb_data_t exp_err);
        logic b;
        int   idx;
        words_sent = 0;
        fork
            begin
                for (int w = 0; w < PRBS_WORDS + 10; w++) begin
                    @(negedge clk_adc);
                    for (int k = 0; k < `NTI; k++) begin
                        b   = prbs_next();
                        idx = w * `NTI + k;
                        if (idx == flip0 || idx == flip1 || idx == flip2) begin
                            b = !b;
                        end
                        adc_mag[k]  = 8'd40;
                        adc_sign[k] = b;
                    end
                    words_sent = w + 1;
                end
            end
            begin
                // Clear lands just as word 0 reaches the checker
                wb_write(`REG_CTRL, 32'h4);
                // Word n is counted 3 edges after it is driven
                wait (words_sent == PRBS_WORDS + 2);
                read_check(name, `REG_PRBS_TOTAL, wb_data_t'(PRBS_WORDS * `NTI - 7));
                read_check(name, `REG_PRBS_ERR, exp_err);
            end
        join
    endtask

    task automatic prbs_counting();
        for (int k = 0; k < `NTI; k++) begin
            wb_write(wb_addr_t'(`REG_EXT_OFS0 + k), '0);
        end
        wb_write(`REG_CTRL, '0);
        prbs_run("prbs clean", -1, -1, -1, '0);
        // Each flip is seen as the bit itself and twice as a predictor tap
        prbs_run("prbs flips", 100, 613, 1210, 32'd9);
    endtask

    task automatic cdr_tracking();
        wb_data_t pi_mask;
        wb_data_t a;
        wb_data_t b;
        wb_data_t c;
        wb_data_t d;
        pi_mask = wb_data_t'((1 << `NPI) - 1);
        @(negedge clk_adc);
        for (int k = 0; k < `NTI; k++) begin
            adc_mag[k]  = 8'd40;
            adc_sign[k] = 1'b1;
        end
        wb_write(`REG_PI_OFFSET, wb_data_t'(PI_OFS));
        wb_write(`REG_CDR_STEP, wb_data_t'(CDR_STEP));
        wb_write(`REG_CTRL, 32'h2);
        repeat (10) @(negedge clk_adc);
        compare_pi_port("cdr zero sum port", pi_ctl_t'(PI_OFS));
        read_check("cdr zero sum", `REG_PI_CTL, wb_data_t'(PI_OFS));
        wb_write(`REG_CTRL, '0);
        // +10 +40 -10 -40 gives a detector sum of +120 every word
        @(negedge clk_adc);
        adc_mag  = '{8'd10, 8'd40, 8'd10, 8'd40};
        adc_sign = 4'b0011;
        repeat (5) @(negedge clk_adc);
        wb_write(`REG_CTRL, 32'h2);
        repeat (6) @(negedge clk_adc);
        wb_read(`REG_PI_CTL, a);
        wb_read(`REG_PI_CTL, b);
        checks++;
        if (((b - a) & pi_mask) !== wb_data_t'(2 * CDR_STEP)) begin
            $display("CHECK FAILED cdr rate: expected %0h, actual %0h",
                     2 * CDR_STEP, (b - a) & pi_mask);
            errors++;
        end
        checks++;
        if (a == wb_data_t'(PI_OFS) || ((a - wb_data_t'(PI_OFS)) & pi_mask) % CDR_STEP != 0) begin
            $display("cdr step: phase code %0h is not offset plus a whole number of steps", a);
            errors++;
        end
        wb_write(`REG_CTRL, '0);
        repeat (3) @(negedge clk_adc);
        wb_read(`REG_PI_CTL, c);
        repeat (5) @(negedge clk_adc);
        read_check("cdr freeze", `REG_PI_CTL, c);
        compare_pi_port("cdr freeze port", pi_ctl_t'(c));
        wb_read(`REG_PI_CTL, d);
        wb_write(`REG_PI_OFFSET, wb_data_t'(PI_OFS + 500) & pi_mask);
        repeat (3) @(negedge clk_adc);
        read_check("cdr offset shift", `REG_PI_CTL, (d + 32'd500) & pi_mask);
        compare_pi_port("cdr offset shift port", pi_ctl_t'((d + 32'd500) & pi_mask));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, %0d errors so far", WATCHDOG_CYCLES, errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset_i    = 1'b1;
        adc_sign   = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_i   = '0;
        lfsr       = 32'hf44a1a7e;
        prbs_state = 7'h01;
        words_sent = 0;
        errors     = 0;
        checks     = 0;
        for (int k = 0; k < `NTI; k++) begin
            adc_mag[k] = '0;
        end
        repeat (3) @(posedge clk_adc);
        @(negedge clk_adc);
        reset_i = 1'b0;

        register_access();
        unfold_with_offset();
        offset_calibration();
        prbs_counting();
        cdr_tracking();

        $display("tb_rx_core: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
hw/rx_core_pkg.sv
hw/adc_retimer.sv
hw/adc_unfolder.sv
hw/mm_cdr.sv
hw/prbs_checker.sv
hw/wb_regs.sv
hw/rx_core.sv
sim/tb_rx_core.sv

// File: Makefile
# Verilator simulation of the receiver core testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
